/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] xlen_t;    // data or address word
  typedef logic [3:0]  alu_op_t;
  typedef logic [2:0]  npc_sel_t;
  typedef logic [1:0]  wdata_sel_t;
  typedef logic [1:0]  src_sel_t;

  // arithmetic and logic operations
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLL  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_SLT  = 4'd8;
  localparam alu_op_t ALU_SLTU = 4'd9;
  // comparisons for branches, result is 1 or 0 in bit 0
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  localparam npc_sel_t NPC_SEQ    = 3'd0;
  localparam npc_sel_t NPC_JAL    = 3'd1;
  localparam npc_sel_t NPC_JALR   = 3'd2;
  localparam npc_sel_t NPC_BRANCH = 3'd3;
  localparam npc_sel_t NPC_TRAP   = 3'd4;  // ecall and mret take the csr value

  localparam wdata_sel_t WDATA_ALU  = 2'd0;
  localparam wdata_sel_t WDATA_SNPC = 2'd1;  // jal and jalr link value
  localparam wdata_sel_t WDATA_DNPC = 2'd2;  // auipc
  localparam wdata_sel_t WDATA_CSR  = 2'd3;

  // operand sources, SRC_IMM only has a meaning for operand 2
  localparam src_sel_t SRC_REG  = 2'd0;
  localparam src_sel_t SRC_LAST = 2'd1;
  localparam src_sel_t SRC_FWD  = 2'd2;
  localparam src_sel_t SRC_IMM  = 2'd3;

endpackage

`default_nettype wire

/* src/exu_flow_pkg.sv */
`default_nettype none

package exu_flow_pkg;

  localparam int QUEUE_DEPTH    = 4;  // issue queue entries, also the decode credits
  localparam int RESULT_CREDITS = 4;  // writeback buffer slots

  // holds any value from 0 up to either count
  typedef logic [2:0] credit_cnt_t;

  typedef logic [1:0] queue_ptr_t;

endpackage

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*; (
  input  alu_op_t op,
  input  xlen_t   operand1,
  input  xlen_t   operand2,
  output xlen_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand2[4:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;

  always_comb begin
    result = '0;
    case (op)
      ALU_ADD:  result = operand1 + operand2;
      ALU_SUB:  result = operand1 - operand2;
      ALU_AND:  result = operand1 & operand2;
      ALU_OR:   result = operand1 | operand2;
      ALU_XOR:  result = operand1 ^ operand2;
      ALU_SLL:  result = operand1 << shamt;
      ALU_SRL:  result = operand1 >> shamt;
      ALU_SRA:  result = xlen_t'($signed(operand1) >>> shamt);
      // slt and branch conditions only set bit 0
      ALU_SLT:  result[0] = lt_signed;
      ALU_SLTU: result[0] = lt_unsigned;
      ALU_EQ:   result[0] = operand1 == operand2;
      ALU_NE:   result[0] = operand1 != operand2;
      ALU_LT:   result[0] = lt_signed;
      ALU_GE:   result[0] = !lt_signed;
      ALU_LTU:  result[0] = lt_unsigned;
      ALU_GEU:  result[0] = !lt_unsigned;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue import rv_isa_pkg::*, exu_flow_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       in_valid,
  input  xlen_t      in_pc,
  input  xlen_t      in_imm,
  input  xlen_t      in_src1,
  input  xlen_t      in_src2,
  input  alu_op_t    in_alu_op,
  input  src_sel_t   in_op1_sel,
  input  src_sel_t   in_op2_sel,
  input  npc_sel_t   in_npc_sel,
  input  wdata_sel_t in_wdata_sel,
  input  xlen_t      in_csr,
  output logic       head_valid,
  output xlen_t      head_pc,
  output xlen_t      head_imm,
  output xlen_t      head_src1,
  output xlen_t      head_src2,
  output alu_op_t    head_alu_op,
  output src_sel_t   head_op1_sel,
  output src_sel_t   head_op2_sel,
  output npc_sel_t   head_npc_sel,
  output wdata_sel_t head_wdata_sel,
  output xlen_t      head_csr,
  input  logic       pop,
  input  logic       flush,
  output logic       credit
);

  xlen_t      pc_mem[QUEUE_DEPTH];
  xlen_t      imm_mem[QUEUE_DEPTH];
  xlen_t      src1_mem[QUEUE_DEPTH];
  xlen_t      src2_mem[QUEUE_DEPTH];
  xlen_t      csr_mem[QUEUE_DEPTH];
  alu_op_t    alu_op_mem[QUEUE_DEPTH];
  src_sel_t   op1_sel_mem[QUEUE_DEPTH];
  src_sel_t   op2_sel_mem[QUEUE_DEPTH];
  npc_sel_t   npc_sel_mem[QUEUE_DEPTH];
  wdata_sel_t wdata_sel_mem[QUEUE_DEPTH];

  queue_ptr_t  wr_ptr;
  queue_ptr_t  rd_ptr;
  credit_cnt_t count;
  logic        push;
  logic        popped;

  assign push = in_valid && !flush;  // an issue in the redirect cycle is dropped

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_ptr]        <= in_pc;
      imm_mem[wr_ptr]       <= in_imm;
      src1_mem[wr_ptr]      <= in_src1;
      src2_mem[wr_ptr]      <= in_src2;
      csr_mem[wr_ptr]       <= in_csr;
      alu_op_mem[wr_ptr]    <= in_alu_op;
      op1_sel_mem[wr_ptr]   <= in_op1_sel;
      op2_sel_mem[wr_ptr]   <= in_op2_sel;
      npc_sel_mem[wr_ptr]   <= in_npc_sel;
      wdata_sel_mem[wr_ptr] <= in_wdata_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, pointers wrap
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
    end
  end

  // the sender gets its credits back in bulk after a flush, so no pulse then
  always_ff @(posedge clock) begin
    if (reset) popped <= 1'b0;
    else popped <= pop && !flush;
  end

  assign credit = popped && !flush;  // the redirecting entry returns no credit of its own

  assign head_valid     = count != '0;
  assign head_pc        = pc_mem[rd_ptr];
  assign head_imm       = imm_mem[rd_ptr];
  assign head_src1      = src1_mem[rd_ptr];
  assign head_src2      = src2_mem[rd_ptr];
  assign head_csr       = csr_mem[rd_ptr];
  assign head_alu_op    = alu_op_mem[rd_ptr];
  assign head_op1_sel   = op1_sel_mem[rd_ptr];
  assign head_op2_sel   = op2_sel_mem[rd_ptr];
  assign head_npc_sel   = npc_sel_mem[rd_ptr];
  assign head_wdata_sel = wdata_sel_mem[rd_ptr];

endmodule

`default_nettype wire

/* src/exec_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_stage import rv_isa_pkg::*, exu_flow_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       head_valid,
  input  xlen_t      head_pc,
  input  xlen_t      head_imm,
  input  xlen_t      head_src1,
  input  xlen_t      head_src2,
  input  alu_op_t    head_alu_op,
  input  src_sel_t   head_op1_sel,
  input  src_sel_t   head_op2_sel,
  input  npc_sel_t   head_npc_sel,
  input  wdata_sel_t head_wdata_sel,
  input  xlen_t      head_csr,
  output logic       pop,
  output logic       flush,
  output alu_op_t    alu_op,
  output xlen_t      alu_operand1,
  output xlen_t      alu_operand2,
  input  xlen_t      alu_result,
  input  xlen_t      forward_data,
  output logic       result_valid,
  output xlen_t      result_wdata,
  output xlen_t      result_store_data,
  output logic       redirect,
  output xlen_t      redirect_pc,
  input  logic       result_credit
);

  xlen_t       operand1_q;
  xlen_t       operand2_q;
  xlen_t       store_q;
  xlen_t       snpc_q;
  xlen_t       dnpc_q;
  xlen_t       csr_q;
  alu_op_t     alu_op_q;
  npc_sel_t    npc_sel_q;
  wdata_sel_t  wdata_sel_q;
  credit_cnt_t credits;

  // SRC_IMM falls back to the register value here, operand 2 handles the immediate itself
  function automatic xlen_t pick_source(src_sel_t sel, xlen_t reg_value, xlen_t last,
                                        xlen_t fwd);
    case (sel)
      SRC_LAST: pick_source = last;
      SRC_FWD:  pick_source = fwd;
      default:  pick_source = reg_value;
    endcase
  endfunction

  assign pop   = head_valid && credits != '0 && !redirect;
  assign flush = redirect;

  // the registers below only change at a pop, so result_wdata is always the newest result
  always_ff @(posedge clock) begin
    if (pop) begin
      alu_op_q    <= head_alu_op;
      operand1_q  <= pick_source(head_op1_sel, head_src1, result_wdata, forward_data);
      operand2_q  <= (head_op2_sel == SRC_IMM) ? head_imm
                   : pick_source(head_op2_sel, head_src2, result_wdata, forward_data);
      store_q     <= pick_source(head_op2_sel, head_src2, result_wdata, forward_data);
      snpc_q      <= head_pc + 32'd4;
      dnpc_q      <= head_pc + head_imm;
      csr_q       <= head_csr;
      npc_sel_q   <= head_npc_sel;
      wdata_sel_q <= head_wdata_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
      credits      <= credit_cnt_t'(RESULT_CREDITS);
    end else begin
      result_valid <= pop;
      credits      <= credits - credit_cnt_t'(pop) + credit_cnt_t'(result_credit);
    end
  end

  assign alu_op       = alu_op_q;
  assign alu_operand1 = operand1_q;
  assign alu_operand2 = operand2_q;

  always_comb begin
    case (wdata_sel_q)
      WDATA_SNPC: result_wdata = snpc_q;
      WDATA_DNPC: result_wdata = dnpc_q;
      WDATA_CSR:  result_wdata = csr_q;
      default:    result_wdata = alu_result;
    endcase
  end

  always_comb begin
    case (npc_sel_q)
      NPC_JAL:    redirect_pc = dnpc_q;
      NPC_JALR:   redirect_pc = alu_result & ~xlen_t'(1);
      NPC_BRANCH: redirect_pc = alu_result[0] ? dnpc_q : snpc_q;  // untaken still redirects
      NPC_TRAP:   redirect_pc = csr_q;
      default:    redirect_pc = snpc_q;
    endcase
  end

  assign redirect          = result_valid && npc_sel_q != NPC_SEQ;
  assign result_store_data = store_q;

endmodule

`default_nettype wire

/* src/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core import rv_isa_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  input  xlen_t      issue_pc,
  input  xlen_t      issue_imm,
  input  xlen_t      issue_src1,
  input  xlen_t      issue_src2,
  input  alu_op_t    issue_alu_op,
  input  src_sel_t   issue_op1_sel,
  input  src_sel_t   issue_op2_sel,
  input  npc_sel_t   issue_npc_sel,
  input  wdata_sel_t issue_wdata_sel,
  input  xlen_t      issue_csr,
  output logic       issue_credit,
  output logic       result_valid,
  output xlen_t      result_wdata,
  output xlen_t      result_store_data,
  output logic       redirect,
  output xlen_t      redirect_pc,
  input  logic       result_credit,
  input  xlen_t      forward_data
);

  logic       head_valid;
  xlen_t      head_pc;
  xlen_t      head_imm;
  xlen_t      head_src1;
  xlen_t      head_src2;
  alu_op_t    head_alu_op;
  src_sel_t   head_op1_sel;
  src_sel_t   head_op2_sel;
  npc_sel_t   head_npc_sel;
  wdata_sel_t head_wdata_sel;
  xlen_t      head_csr;
  logic       pop;
  logic       flush;
  alu_op_t    alu_op;
  xlen_t      alu_operand1;
  xlen_t      alu_operand2;
  xlen_t      alu_result;

  issue_queue queue (
    .clock, .reset,
    .in_valid(issue_valid), .in_pc(issue_pc), .in_imm(issue_imm),
    .in_src1(issue_src1), .in_src2(issue_src2), .in_alu_op(issue_alu_op),
    .in_op1_sel(issue_op1_sel), .in_op2_sel(issue_op2_sel),
    .in_npc_sel(issue_npc_sel), .in_wdata_sel(issue_wdata_sel), .in_csr(issue_csr),
    .head_valid, .head_pc, .head_imm, .head_src1, .head_src2, .head_alu_op,
    .head_op1_sel, .head_op2_sel, .head_npc_sel, .head_wdata_sel, .head_csr,
    .pop, .flush, .credit(issue_credit)
  );

  exec_stage stage (
    .clock, .reset,
    .head_valid, .head_pc, .head_imm, .head_src1, .head_src2, .head_alu_op,
    .head_op1_sel, .head_op2_sel, .head_npc_sel, .head_wdata_sel, .head_csr,
    .pop, .flush, .alu_op, .alu_operand1, .alu_operand2, .alu_result, .forward_data,
    .result_valid, .result_wdata, .result_store_data, .redirect, .redirect_pc,
    .result_credit
  );

  alu alu_unit (
    .op(alu_op), .operand1(alu_operand1), .operand2(alu_operand2), .result(alu_result)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;  // 4 ns period
  end

  // reset covers the first three rising edges, then drops on a falling edge
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/exec_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_checker import exu_flow_pkg::*; (
  input logic        clock,
  input logic        reset,
  input logic        result_valid,
  input logic        result_credit,
  input logic        redirect,
  input logic        issue_credit,
  input credit_cnt_t credits
);

  credit_cnt_t slots;  // writeback slots as seen on the ports

  always_ff @(posedge clock) begin
    if (reset) slots <= credit_cnt_t'(RESULT_CREDITS);
    else slots <= slots - credit_cnt_t'(result_valid) + credit_cnt_t'(result_credit);
  end

  // a result needs a free slot counting every credit returned before it
  a_result_has_credit: assert property (@(posedge clock) disable iff (reset)
    result_valid |-> slots != '0)
    else $error("result_valid issued without a result credit");

  a_credit_bounded: assert property (@(posedge clock) disable iff (reset)
    credits <= credit_cnt_t'(RESULT_CREDITS))
    else $error("result credit count above the buffer size");

  // the redirect hands all queue credits back at once
  a_no_credit_on_redirect: assert property (@(posedge clock) disable iff (reset)
    !(issue_credit && redirect))
    else $error("issue_credit and redirect high together");

  a_redirect_with_result: assert property (@(posedge clock) disable iff (reset)
    redirect |-> result_valid)
    else $error("redirect without result_valid");

  a_quiet_after_reset: assert property (@(posedge clock)
    reset |=> !result_valid && !redirect && !issue_credit)
    else $error("output active right after reset");

endmodule

bind exec_core exec_core_checker result_checks (
  .clock(clock),
  .reset(reset),
  .result_valid(result_valid),
  .result_credit(result_credit),
  .redirect(redirect),
  .issue_credit(issue_credit),
  .credits(stage.credits)
);

`default_nettype wire

/* bench/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb import rv_isa_pkg::*, exu_flow_pkg::*; ();

  typedef struct packed {
    xlen_t      pc;
    xlen_t      imm;
    xlen_t      src1;
    xlen_t      src2;
    xlen_t      csr;
    alu_op_t    alu_op;
    src_sel_t   op1_sel;
    src_sel_t   op2_sel;
    npc_sel_t   npc_sel;
    wdata_sel_t wdata_sel;
  } item_t;

  localparam int TOTAL_ITEMS = 49;  // sum of the items of all tests

  logic       clock;
  logic       reset;
  logic       issue_valid = 1'b0;
  xlen_t      issue_pc = '0;
  xlen_t      issue_imm = '0;
  xlen_t      issue_src1 = '0;
  xlen_t      issue_src2 = '0;
  alu_op_t    issue_alu_op = '0;
  src_sel_t   issue_op1_sel = '0;
  src_sel_t   issue_op2_sel = '0;
  npc_sel_t   issue_npc_sel = '0;
  wdata_sel_t issue_wdata_sel = '0;
  xlen_t      issue_csr = '0;
  logic       issue_credit;
  logic       result_valid;
  xlen_t      result_wdata;
  xlen_t      result_store_data;
  logic       redirect;
  xlen_t      redirect_pc;
  logic       result_credit = 1'b0;
  xlen_t      forward_data = '0;

  integer seed = 32'h78ed7748;
  item_t  pending[$];   // waiting in the decode model
  item_t  expected[$];  // issued, result not seen yet
  item_t  issued;
  item_t  cur;
  int     dec_credits = QUEUE_DEPTH;
  int     owed = 0;
  logic   hold_credits = 1'b0;
  int     results = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  xlen_t  last_wdata = '0;
  xlen_t  exp_wdata;
  xlen_t  exp_store;
  logic   exp_redirect;
  xlen_t  exp_pc;

  clock_gen clocks (.clock, .reset);

  exec_core UUT (
    .clock, .reset, .issue_valid, .issue_pc, .issue_imm, .issue_src1, .issue_src2,
    .issue_alu_op, .issue_op1_sel, .issue_op2_sel, .issue_npc_sel, .issue_wdata_sel,
    .issue_csr, .issue_credit, .result_valid, .result_wdata, .result_store_data,
    .redirect, .redirect_pc, .result_credit, .forward_data
  );

  function automatic xlen_t alu_model(alu_op_t op, xlen_t a, xlen_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
      ALU_SLT,
      ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU,
      ALU_LTU:  return {31'b0, a < b};
      ALU_EQ:   return {31'b0, a == b};
      ALU_NE:   return {31'b0, a != b};
      ALU_GE:   return {31'b0, $signed(a) >= $signed(b)};
      default:  return {31'b0, a >= b};
    endcase
  endfunction

  function automatic xlen_t operand_value(src_sel_t sel, xlen_t reg_value, xlen_t last,
                                          xlen_t fwd);
    if (sel == SRC_LAST) return last;
    if (sel == SRC_FWD) return fwd;
    return reg_value;
  endfunction

  function automatic void expect_result(input item_t it, input xlen_t last, input xlen_t fwd,
                                        output xlen_t wdata, output xlen_t store,
                                        output logic redir, output xlen_t rpc);
    xlen_t a;
    xlen_t b;
    xlen_t alu_out;
    xlen_t snpc;
    xlen_t dnpc;
    a = operand_value(it.op1_sel, it.src1, last, fwd);
    store = operand_value(it.op2_sel, it.src2, last, fwd);
    b = (it.op2_sel == SRC_IMM) ? it.imm : store;
    alu_out = alu_model(it.alu_op, a, b);
    snpc = it.pc + 32'd4;
    dnpc = it.pc + it.imm;
    case (it.wdata_sel)
      WDATA_SNPC: wdata = snpc;
      WDATA_DNPC: wdata = dnpc;
      WDATA_CSR:  wdata = it.csr;
      default:    wdata = alu_out;
    endcase
    redir = it.npc_sel != NPC_SEQ;
    case (it.npc_sel)
      NPC_JAL:    rpc = dnpc;
      NPC_JALR:   rpc = alu_out & 32'hffff_fffe;
      NPC_BRANCH: rpc = alu_out[0] ? dnpc : snpc;
      NPC_TRAP:   rpc = it.csr;
      default:    rpc = snpc;
    endcase
  endfunction

  function automatic item_t make_item(alu_op_t op, src_sel_t s1, src_sel_t s2, npc_sel_t npc,
                                      wdata_sel_t wsel);
    item_t it;
    it.pc = xlen_t'($random(seed)) & 32'hffff_fffc;
    it.imm = xlen_t'($random(seed));
    it.src1 = xlen_t'($random(seed));
    it.src2 = xlen_t'($random(seed));
    it.csr = xlen_t'($random(seed));
    it.alu_op = op;
    it.op1_sel = s1;
    it.op2_sel = s2;
    it.npc_sel = npc;
    it.wdata_sel = wsel;
    return it;
  endfunction

  // decode model, an issue seen together with redirect is dropped by the queue
  always @(negedge clock) begin
    issue_valid = 1'b0;
    if (reset) begin
      dec_credits = QUEUE_DEPTH;
    end else begin
      if (redirect) dec_credits = QUEUE_DEPTH;
      else if (issue_credit) dec_credits = dec_credits + 1;
      if (pending.size() != 0 && dec_credits > 0) begin
        issued = pending.pop_front();
        issue_pc = issued.pc;
        issue_imm = issued.imm;
        issue_src1 = issued.src1;
        issue_src2 = issued.src2;
        issue_csr = issued.csr;
        issue_alu_op = issued.alu_op;
        issue_op1_sel = issued.op1_sel;
        issue_op2_sel = issued.op2_sel;
        issue_npc_sel = issued.npc_sel;
        issue_wdata_sel = issued.wdata_sel;
        issue_valid = 1'b1;
        if (!redirect) begin
          expected.push_back(issued);
          dec_credits = dec_credits - 1;
        end
      end
    end
  end

  // writeback side returns one credit per result unless held back
  always @(negedge clock) begin
    if (reset) begin
      owed = 0;
      result_credit = 1'b0;
    end else begin
      if (result_valid) owed = owed + 1;
      if (!hold_credits && owed > 0) begin
        result_credit = 1'b1;
        owed = owed - 1;
      end else begin
        result_credit = 1'b0;
      end
    end
  end

  always @(negedge clock) begin
    if (!reset && result_valid) begin
      if (expected.size() == 0) begin
        $display("unexpected result at %0t with no item outstanding", $time);
        fail_count = fail_count + 1;
      end else begin
        cur = expected.pop_front();
        expect_result(cur, last_wdata, forward_data, exp_wdata, exp_store, exp_redirect,
                      exp_pc);
        last_wdata = exp_wdata;
        if (result_wdata !== exp_wdata) begin
          $display("[FAIL] %0t result_wdata expected %h actual %h", $time, exp_wdata,
                   result_wdata);
          fail_count = fail_count + 1;
        end else pass_count = pass_count + 1;
        if (result_store_data !== exp_store) begin
          $display("[FAIL] %0t result_store_data expected %h actual %h", $time, exp_store,
                   result_store_data);
          fail_count = fail_count + 1;
        end else pass_count = pass_count + 1;
        if (redirect !== exp_redirect) begin
          $display("[FAIL] %0t redirect expected %b actual %b", $time, exp_redirect, redirect);
          fail_count = fail_count + 1;
        end else pass_count = pass_count + 1;
        if (exp_redirect && redirect_pc !== exp_pc) begin
          $display("[FAIL] %0t redirect_pc expected %h actual %h", $time, exp_pc, redirect_pc);
          fail_count = fail_count + 1;
        end else pass_count = pass_count + 1;
      end
      results = results + 1;
      if (redirect) expected.delete();  // younger items were squashed
    end
  end

  initial begin
    repeat (TOTAL_ITEMS * 20 + 200) @(posedge clock);
    $display("timeout: the tests did not finish in the allowed number of cycles");
    $display("Test FAILED");
    $finish;
  end

  task automatic wait_idle();
    @(posedge clock);
    while (pending.size() != 0 || expected.size() != 0 || owed != 0) @(posedge clock);
  endtask

  task automatic report_test(int n, string name, int base_res, int base_fail);
    $display("test %0d %s done: %0d results, %0d new failures", n, name, results - base_res,
             fail_count - base_fail);
  endtask

  task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
      $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
      fail_count = fail_count + 1;
    end else pass_count = pass_count + 1;
  endtask

  initial begin
    int    base_res;
    int    base_fail;
    item_t it;
    @(negedge reset);
    base_fail = fail_count;
    repeat (5) begin
      @(negedge clock);
      if (result_valid || redirect || issue_credit) begin
        $display("an output went high after reset before any issue at %0t", $time);
        fail_count = fail_count + 1;
      end
    end
    report_test(6, "reset values", results, base_fail);

    base_res = results;
    base_fail = fail_count;
    repeat (16) begin
      it = make_item(alu_op_t'($random(seed)), SRC_REG, $random(seed) & 1 ? SRC_IMM : SRC_REG,
                     NPC_SEQ, wdata_sel_t'($random(seed)));
      pending.push_back(it);
    end
    wait_idle();
    check_count("results of test 1", 16, results - base_res);
    report_test(1, "straight-line alu", base_res, base_fail);

    @(negedge clock);
    forward_data = xlen_t'($random(seed));
    base_res = results;
    base_fail = fail_count;
    repeat (16) begin
      it = make_item(alu_op_t'($random(seed)), src_sel_t'($random(seed)),
                     src_sel_t'($random(seed)), NPC_SEQ, WDATA_ALU);
      pending.push_back(it);
    end
    wait_idle();
    report_test(2, "forwarding", base_res, base_fail);

    base_res = results;
    base_fail = fail_count;
    pending.push_back(make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_JAL, WDATA_SNPC));
    wait_idle();
    it = make_item(ALU_ADD, SRC_REG, SRC_IMM, NPC_JALR, WDATA_SNPC);
    it.src1 = it.src1 & 32'hffff_fffe;
    it.imm = it.imm | 32'h1;  // odd target, bit 0 must be cleared
    pending.push_back(it);
    wait_idle();
    it = make_item(ALU_EQ, SRC_REG, SRC_REG, NPC_BRANCH, WDATA_ALU);
    it.src2 = it.src1;
    pending.push_back(it);
    wait_idle();
    it = make_item(ALU_NE, SRC_REG, SRC_REG, NPC_BRANCH, WDATA_ALU);
    it.src2 = it.src1;
    pending.push_back(it);
    wait_idle();
    pending.push_back(make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_TRAP, WDATA_CSR));
    wait_idle();
    check_count("results of test 3", 5, results - base_res);
    report_test(3, "control transfers", base_res, base_fail);

    base_res = results;
    base_fail = fail_count;
    pending.push_back(make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_JAL, WDATA_SNPC));
    pending.push_back(make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_SEQ, WDATA_CSR));
    pending.push_back(make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_SEQ, WDATA_CSR));
    wait_idle();
    check_count("decode credits after redirect", QUEUE_DEPTH, dec_credits);
    it = make_item(ALU_ADD, SRC_REG, SRC_REG, NPC_SEQ, WDATA_CSR);
    it.csr = 32'h5a5a_0001;  // marker value
    pending.push_back(it);
    wait_idle();
    check_count("results of test 4", 2, results - base_res);
    report_test(4, "squash", base_res, base_fail);

    base_res = results;
    base_fail = fail_count;
    hold_credits = 1'b1;
    repeat (8) begin
      it = make_item(alu_op_t'($random(seed)), SRC_REG, SRC_IMM, NPC_SEQ, WDATA_ALU);
      pending.push_back(it);
    end
    repeat (40) @(posedge clock);
    check_count("results while credits held", RESULT_CREDITS, results - base_res);
    hold_credits = 1'b0;
    wait_idle();
    check_count("results of test 5", 8, results - base_res);
    report_test(5, "back-pressure", base_res, base_fail);

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
src/rv_isa_pkg.sv
src/exu_flow_pkg.sv
src/alu.sv
src/issue_queue.sv
src/exec_stage.sv
src/exec_core.sv
bench/clock_gen.sv
bench/exec_core_checker.sv
bench/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# builds the exec_core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module exec_core_tb -o exec_core_sim

./obj_dir/exec_core_sim > sim.log
cat sim.log

# exit status follows the pass message in the log
grep -q "Test OK" sim.log
